// ==== tb/graduation_stim.txt ====
# D pc store cause count | W port index cause | F index | I cycles | E pc count | X cause pc
# All fields hex, E and D counts expand to pc, pc+4, ...
# Out-of-order writeback, dual retire, stores without writeback
D 100 0 0 2
D 108 1 0 1
D 10c 0 0 1
W 0 3 0
W 1 1 0
W 0 0 0
D 110 1 0 1
E 100 5
I 4
# Younger exception first, the older one must win
D 200 0 0 4
W 1 8 7
W 0 6 3
W 1 5 0
E 200 1
X 3 204
I 4
# Partial flush drops entries 2 and 3 and their pending exception
D 300 0 0 4
W 1 3 9
F 1
D 310 0 0 1
D 314 1 0 1
W 0 1 0
W 1 2 0
W 0 0 0
E 300 2
E 310 2
I 4
# Fill to full behind an unfinished head, then one more dispatch
D 400 0 0 1
D 404 1 0 e
W 0 4 0
D 43c 1 0 1
E 400 10
I 2

// ==== build.f ====
common/grad_pkg.sv
graduation/graduation_list.sv
graduation/exception_tracker.sv
verilog/commit_unit.sv
verilog/graduation_top.sv
tb/tb_clock_gen.sv
tb/graduation_sva.sv
tb/graduation_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= graduation_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/graduation_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module graduation_tb
    import grad_pkg::*;
();

    localparam int WAIT_LIMIT = 400;   // Cycles before any wait gives up

    logic                   clk;
    logic                   rstn;
    gl_instr_t              dispatch;
    exception_t             dispatch_ex;
    gl_wb_t    [NUM_WB-1:0] wb;
    logic                   flush;
    gl_index_t              flush_idx;
    gl_index_t              assigned_idx;
    pc_t       [1:0]        commit;
    logic      [1:0]        commit_valid;
    exception_t             exc;
    logic                   full;
    logic                   empty;

    pc_t         pc_of [GL_ENTRIES];   // Dispatched pc per entry
    pc_t         exp_pcs[$];
    pc_t         got_pcs[$];
    logic [35:0] exp_exc[$];           // {cause, pc}
    logic [35:0] got_exc[$];
    int          dual_commits;
    int          full_waits;
    int          seed;
    gl_index_t   exp_idx;              // Next tail expected from the ring rules

    tb_clock_gen u_clk (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    graduation_top dut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .dispatch_i     (dispatch),
        .dispatch_ex_i  (dispatch_ex),
        .wb_i           (wb),
        .flush_i        (flush),
        .flush_idx_i    (flush_idx),
        .assigned_idx_o (assigned_idx),
        .commit_o       (commit),
        .commit_valid_o (commit_valid),
        .exc_o          (exc),
        .full_o         (full),
        .empty_o        (empty)
    );

    task automatic abort_run(input string why);
        $display("Checks failed");
        $fatal(1, why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run("stopped at the first mismatch");
        end
    endtask

    // Drive point is 1 ns after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic drive_dispatch(input pc_t pc, input logic st, input exc_cause_t cause);
        int waits;
        waits                = 0;
        dispatch.valid       = 1'b1;
        dispatch.pc          = pc;
        dispatch.is_store    = st;
        dispatch.ex_valid    = (cause != '0);
        dispatch_ex.valid    = (cause != '0);
        dispatch_ex.cause    = cause;
        dispatch_ex.pc       = pc;
        while (full) begin   // Held high while the list has no room
            if (waits == WAIT_LIMIT) begin
                abort_run("dispatch timed out while the list stayed full");
            end
            full_waits++;
            waits++;
            next_cycle();
        end
        check_value("assigned_idx_o", 32'(assigned_idx), 32'(exp_idx));
        pc_of[assigned_idx] = pc;
        next_cycle();
        exp_idx     = exp_idx + gl_index_t'(1);
        dispatch    = '0;
        dispatch_ex = '0;
    endtask

    task automatic drive_writeback(input int port, input gl_index_t idx,
                                   input exc_cause_t cause);
        wb[port].en       = 1'b1;
        wb[port].index    = idx;
        wb[port].ex.valid = (cause != '0);
        wb[port].ex.cause = cause;
        wb[port].ex.pc    = pc_of[idx];
        next_cycle();
        wb[port] = '0;
    endtask

    task automatic drive_flush(input gl_index_t idx);
        flush     = 1'b1;
        flush_idx = idx;
        next_cycle();
        flush     = 1'b0;
        exp_idx   = idx + gl_index_t'(1);   // Youngest kept entry is idx
    endtask

    task automatic wait_for_empty();
        int waits;
        waits = 0;
        while (!empty) begin
            if (waits == WAIT_LIMIT) begin
                abort_run("list did not drain before the end of the run");
            end
            waits++;
            next_cycle();
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = 0;
        while (c != 10 && c >= 0) begin   // Up to newline or end of file
            c = $fgetc(fd);
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            abort_run("malformed line in the stimulus file");
        end
    endtask

    // Outputs are stable by mid-cycle
    always @(negedge clk) begin
        if (rstn) begin
            if (commit_valid[0]) begin
                got_pcs.push_back(commit[0]);
            end
            if (commit_valid[1]) begin
                got_pcs.push_back(commit[1]);
            end
            if (commit_valid == 2'b11) begin
                dual_commits++;
            end
            if (exc.valid) begin
                got_exc.push_back({exc.cause, exc.pc});
                check_value("empty_o during exc_o", 32'(empty), 32'd1);   // List cleared
                exp_idx = '0;
            end
        end
    end

    initial begin
        int          fd;
        int          c;
        int          n;
        int          waits;
        int          extra;
        logic [7:0]  cmd;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic        done;

        dispatch     = '0;
        dispatch_ex  = '0;
        wb           = '0;
        flush        = 1'b0;
        flush_idx    = '0;
        dual_commits = 0;
        full_waits   = 0;
        seed         = 32'h3a04;
        exp_idx      = '0;

        waits = 0;
        while (rstn !== 1'b1) begin
            if (waits == WAIT_LIMIT) begin
                abort_run("reset was never released");
            end
            waits++;
            @(posedge clk);
        end
        #1;

        fd = $fopen("tb/graduation_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tb/graduation_stim.txt");
        end

        done = 1'b0;
        while (!done) begin
            c = $fgetc(fd);
            if (c < 0) begin
                done = 1'b1;
            end else begin
                cmd = 8'(c);
                case (cmd)
                    "#": skip_line(fd);
                    "D": begin
                        n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                        expect_fields(n, 4);
                        for (int i = 0; i < int'(f3); i++) begin
                            drive_dispatch(f0 + 32'(4 * i), f1[0], f2[3:0]);
                        end
                    end
                    "W": begin
                        n = $fscanf(fd, "%h %h %h", f0, f1, f2);
                        expect_fields(n, 3);
                        drive_writeback(int'(f0), f1[GL_INDEX_W-1:0], f2[3:0]);
                    end
                    "F": begin
                        n = $fscanf(fd, "%h", f0);
                        expect_fields(n, 1);
                        drive_flush(f0[GL_INDEX_W-1:0]);
                    end
                    "I": begin
                        n = $fscanf(fd, "%h", f0);
                        expect_fields(n, 1);
                        extra = $random(seed) & 3;   // Up to 3 extra idle cycles
                        idle_cycles(int'(f0) + extra);
                    end
                    "E": begin
                        n = $fscanf(fd, "%h %h", f0, f1);
                        expect_fields(n, 2);
                        for (int i = 0; i < int'(f1); i++) begin
                            exp_pcs.push_back(f0 + 32'(4 * i));
                        end
                    end
                    "X": begin
                        n = $fscanf(fd, "%h %h", f0, f1);
                        expect_fields(n, 2);
                        exp_exc.push_back({f0[3:0], f1});
                    end
                    " ", "\n", "\r", "\t": ;
                    default: abort_run("unknown command in the stimulus file");
                endcase
            end
        end
        $fclose(fd);

        wait_for_empty();
        idle_cycles(3);   // Last commit registers drain

        check_value("commit count", 32'(got_pcs.size()), 32'(exp_pcs.size()));
        foreach (exp_pcs[i]) begin
            check_value("commit_o", got_pcs[i], exp_pcs[i]);
        end
        check_value("exception count", 32'(got_exc.size()), 32'(exp_exc.size()));
        foreach (exp_exc[i]) begin
            check_value("exc_o.cause", 32'(got_exc[i][35:32]), 32'(exp_exc[i][35:32]));
            check_value("exc_o.pc", got_exc[i][31:0], exp_exc[i][31:0]);
        end
        check_value("dual commit seen", 32'(dual_commits != 0), 32'd1);
        check_value("dispatch held by full_o", 32'(full_waits != 0), 32'd1);
        if (dut.u_sva.fail_count != 0) begin
            abort_run("a bound assertion failed during the run");
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/graduation_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module graduation_sva
    import grad_pkg::*;
(
    input  wire              clk_i,
    input  wire              rstn_i,
    input  logic       [1:0] commit_valid_i,
    input  logic             empty_i,
    input  exception_t       exc_i
);

    int fail_count = 0;   // Failed properties so far

    // Slot 0 always holds the oldest retiring entry
    slot_order: assert property (@(posedge clk_i) disable iff (!rstn_i)
        commit_valid_i[1] |-> commit_valid_i[0])
        else begin
            fail_count++;
            $error("commit slot 1 valid without slot 0");
        end

    // Nothing can retire out of an empty list
    no_commit_from_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(empty_i) |-> (commit_valid_i == 2'b00))
        else begin
            fail_count++;
            $error("commit seen one cycle after an empty list");
        end

    exc_single_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        exc_i.valid |=> !exc_i.valid)
        else begin
            fail_count++;
            $error("exception report longer than one cycle");
        end

endmodule

bind graduation_top graduation_sva u_sva (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .commit_valid_i (commit_valid_o),
    .empty_i        (empty_o),
    .exc_i          (exc_o)
);

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;                 // Reset from time zero
        repeat (5) @(posedge clk_o);
        #1 rstn_o = 1'b1;              // Released away from the edge
    end

    always #2 clk_o = ~clk_o;          // 4 ns period

endmodule

`default_nettype wire

// ==== verilog/graduation_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module graduation_top
    import grad_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rstn_i,

    input  gl_instr_t               dispatch_i,
    input  exception_t              dispatch_ex_i,
    input  gl_wb_t     [NUM_WB-1:0] wb_i,
    input  logic                    flush_i,
    input  gl_index_t               flush_idx_i,

    output gl_index_t               assigned_idx_o,
    output pc_t        [1:0]        commit_o,
    output logic       [1:0]        commit_valid_o,
    output exception_t              exc_o,
    output logic                    full_o,
    output logic                    empty_o
);

    gl_index_t        head;
    gl_instr_t  [1:0] head_pair;
    logic       [1:0] head_ready;
    logic       [1:0] retire;
    logic             commit_flush;
    exception_t       oldest;
    logic             disp_we;

    // Same acceptance rule as inside the list
    assign disp_we = dispatch_i.valid & ~full_o & ~flush_i & ~commit_flush;

    graduation_list u_list (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .dispatch_i     (dispatch_i),
        .wb_i           (wb_i),
        .flush_i        (flush_i),
        .flush_idx_i    (flush_idx_i),
        .commit_flush_i (commit_flush),
        .retire_i       (retire),
        .assigned_idx_o (assigned_idx_o),
        .head_o         (head),
        .head_pair_o    (head_pair),
        .head_ready_o   (head_ready),
        .full_o         (full_o),
        .empty_o        (empty_o)
    );

    exception_tracker u_tracker (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .disp_ex_i      (dispatch_ex_i),
        .disp_we_i      (disp_we),
        .tail_i         (assigned_idx_o),
        .head_i         (head),
        .wb_i           (wb_i),
        .flush_i        (flush_i),
        .flush_idx_i    (flush_idx_i),
        .commit_flush_i (commit_flush),
        .oldest_o       (oldest),
        .oldest_idx_o   ()             // Index not needed by commit
    );

    commit_unit u_commit (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .head_pair_i    (head_pair),
        .head_ready_i   (head_ready),
        .empty_i        (empty_o),
        .oldest_i       (oldest),
        .retire_o       (retire),
        .commit_flush_o (commit_flush),
        .commit_o       (commit_o),
        .commit_valid_o (commit_valid_o),
        .exc_o          (exc_o)
    );

endmodule

`default_nettype wire

// ==== verilog/commit_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_unit
    import grad_pkg::*;
(
    input  wire                   clk_i,
    input  wire                   rstn_i,

    input  gl_instr_t   [1:0]     head_pair_i,
    input  logic        [1:0]     head_ready_i,
    input  logic                  empty_i,
    input  exception_t            oldest_i,

    output logic        [1:0]     retire_o,        // 0, 1 or 2 entries
    output logic                  commit_flush_o,

    output pc_t         [1:0]     commit_o,
    output logic        [1:0]     commit_valid_o,  // Slot 0 is the oldest
    output exception_t            exc_o
);

    commit_state_e state_q;
    commit_state_e state_d;

    logic       [1:0] done;         // Live and finished
    logic       [1:0] commit_valid_d;
    logic       [1:0] commit_valid_q;
    pc_t        [1:0] commit_q;
    exception_t       exc_q;

    assign done[0] = ~empty_i & head_pair_i[0].valid & head_ready_i[0];
    assign done[1] = head_pair_i[1].valid & head_ready_i[1];

    always_comb begin
        state_d        = RUN;   // FLUSH only ever lasts one cycle
        retire_o       = 2'd0;
        commit_flush_o = 1'b0;
        commit_valid_d = 2'b00;

        if (state_q == RUN && done[0]) begin
            if (head_pair_i[0].ex_valid) begin
                commit_flush_o = 1'b1;   // Faulting entry reached the head
                state_d        = FLUSH;
            end else if (done[1] && !head_pair_i[1].ex_valid) begin
                retire_o       = 2'd2;
                commit_valid_d = 2'b11;
            end else begin
                retire_o       = 2'd1;
                commit_valid_d = 2'b01;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q        <= RUN;
            commit_valid_q <= 2'b00;
            exc_q          <= '0;
        end else begin
            state_q        <= state_d;
            commit_valid_q <= commit_valid_d;
            exc_q          <= commit_flush_o ? oldest_i : '0;   // One-cycle report
        end
    end

    always_ff @(posedge clk_i) begin
        commit_q[0] <= head_pair_i[0].pc;
        commit_q[1] <= head_pair_i[1].pc;
    end

    assign commit_o       = commit_q;
    assign commit_valid_o = commit_valid_q;
    assign exc_o          = exc_q;

endmodule

`default_nettype wire

// ==== graduation/exception_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exception_tracker
    import grad_pkg::*;
(
    input  wire                  clk_i,
    input  wire                  rstn_i,

    input  exception_t           disp_ex_i,
    input  logic                 disp_we_i,      // Dispatch accepted this cycle
    input  gl_index_t            tail_i,
    input  gl_index_t            head_i,
    input  gl_wb_t  [NUM_WB-1:0] wb_i,

    input  logic                 flush_i,
    input  gl_index_t            flush_idx_i,
    input  logic                 commit_flush_i,

    output exception_t           oldest_o,
    output gl_index_t            oldest_idx_o
);

    exception_t held_q;
    exception_t held_d;
    gl_index_t  held_idx_q;
    gl_index_t  held_idx_d;

    // Age from the head, smaller is older
    function automatic gl_index_t age_of(gl_index_t idx, gl_index_t head);
        return idx - head;
    endfunction

    always_comb begin
        held_d     = held_q;
        held_idx_d = held_idx_q;

        for (int p = 0; p < NUM_WB; p++) begin
            if (wb_i[p].en && wb_i[p].ex.valid) begin
                if (!held_d.valid ||
                    (age_of(wb_i[p].index, head_i) < age_of(held_idx_d, head_i))) begin
                    held_d     = wb_i[p].ex;
                    held_idx_d = wb_i[p].index;
                end
            end
        end

        // Dispatch sits at the tail, younger than anything held
        if (disp_we_i && disp_ex_i.valid && !held_d.valid) begin
            held_d     = disp_ex_i;
            held_idx_d = tail_i;
        end

        if (commit_flush_i) begin
            held_d     = '0;
            held_idx_d = '0;
        end else if (flush_i && held_d.valid &&
                     (age_of(held_idx_d, head_i) > age_of(flush_idx_i, head_i))) begin
            held_d     = '0;   // Entry cut off by recovery
            held_idx_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            held_q     <= '0;
            held_idx_q <= '0;
        end else begin
            held_q     <= held_d;
            held_idx_q <= held_idx_d;
        end
    end

    assign oldest_o     = held_q;
    assign oldest_idx_o = held_idx_q;

endmodule

`default_nettype wire

// ==== graduation/graduation_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module graduation_list
    import grad_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     rstn_i,

    // Dispatch side, in program order
    input  gl_instr_t               dispatch_i,

    // Completion from execution
    input  gl_wb_t     [NUM_WB-1:0] wb_i,

    // Branch recovery, flush_idx_i stays as youngest entry
    input  logic                    flush_i,
    input  gl_index_t               flush_idx_i,

    // From the commit unit
    input  logic                    commit_flush_i,
    input  logic       [1:0]        retire_i,      // Entries leaving the head

    output gl_index_t               assigned_idx_o,
    output gl_index_t               head_o,
    output gl_instr_t  [1:0]        head_pair_o,   // Head and head+1, valid means live
    output logic       [1:0]        head_ready_o,
    output logic                    full_o,
    output logic                    empty_o
);

    gl_instr_t [GL_ENTRIES-1:0] entries_q;
    gl_instr_t [GL_ENTRIES-1:0] entries_d;
    logic      [GL_ENTRIES-1:0] ready_q;
    logic      [GL_ENTRIES-1:0] ready_d;

    gl_index_t head_q;
    gl_index_t tail_q;
    gl_count_t count_q;

    gl_index_t head_d;
    gl_index_t tail_d;
    gl_count_t count_d;
    gl_index_t head_plus_one;

    logic write_en;

    // Ring offset of an index from a base, wraps on its own
    function automatic gl_index_t ring_offset(gl_index_t idx, gl_index_t base);
        return idx - base;
    endfunction

    assign write_en = dispatch_i.valid & ~full_o & ~flush_i & ~commit_flush_i;

    // Record storage and ready bits
    always_comb begin
        entries_d = entries_q;
        ready_d   = ready_q;

        if (write_en) begin
            entries_d[tail_q] = dispatch_i;
            ready_d[tail_q]   = dispatch_i.is_store | dispatch_i.ex_valid;
        end

        for (int p = 0; p < NUM_WB; p++) begin
            if (wb_i[p].en) begin
                ready_d[wb_i[p].index]            = 1'b1;
                entries_d[wb_i[p].index].ex_valid =
                    entries_q[wb_i[p].index].ex_valid | wb_i[p].ex.valid;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        entries_q <= entries_d;   // Payload only, liveness comes from head and count
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ready_q <= '0;
        end else if (commit_flush_i) begin
            ready_q <= '0;
        end else begin
            ready_q <= ready_d;
        end
    end

    // Pointer and count update
    always_comb begin
        head_d = head_q + gl_index_t'(retire_i);

        if (commit_flush_i) begin
            head_d  = '0;
            tail_d  = '0;
            count_d = '0;
        end else if (flush_i) begin
            tail_d  = flush_idx_i + gl_index_t'(1);
            // At most depth-1 live, so the ring distance is the count
            count_d = {1'b0, ring_offset(tail_d, head_d)};
        end else begin
            tail_d  = tail_q + gl_index_t'(write_en);
            count_d = count_q + gl_count_t'(write_en) - gl_count_t'(retire_i);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_d;
            tail_q  <= tail_d;
            count_q <= count_d;
        end
    end

    assign head_plus_one = head_q + gl_index_t'(1);

    // Unfiltered view of the two oldest slots
    always_comb begin
        head_pair_o[0]       = entries_q[head_q];
        head_pair_o[1]       = entries_q[head_plus_one];
        head_pair_o[0].valid = (count_q != '0);
        head_pair_o[1].valid = (count_q > gl_count_t'(1));
        head_ready_o[0]      = ready_q[head_q];
        head_ready_o[1]      = ready_q[head_plus_one];
    end

    assign assigned_idx_o = tail_q;
    assign head_o         = head_q;
    assign empty_o        = (count_q == '0);
    assign full_o         = (count_q == gl_count_t'(GL_ENTRIES - 1));   // One slot kept free

endmodule

`default_nettype wire

// ==== common/grad_pkg.sv ====
`default_nettype none

package grad_pkg;

    // List geometry
    localparam int GL_ENTRIES = 16;   // Must stay a power of two
    localparam int GL_INDEX_W = 4;
    localparam int NUM_WB     = 2;    // Writeback ports from execution

    // Index of a list entry, wraps with the ring
    typedef logic [GL_INDEX_W-1:0] gl_index_t;

    // Occupancy, one bit wider than the index
    typedef logic [GL_INDEX_W:0] gl_count_t;

    typedef logic [31:0] pc_t;

    // Zero is reserved, never a real cause
    typedef logic [3:0] exc_cause_t;

    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        pc_t        pc;
    } exception_t;

    // One instruction record as held in the list
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic is_store;   // Ready at dispatch, no writeback follows
        logic ex_valid;   // Carries an exception
    } gl_instr_t;

    // One writeback port
    typedef struct packed {
        logic       en;      // Single-cycle strobe
        gl_index_t  index;   // Entry that finished
        exception_t ex;
    } gl_wb_t;

    // Commit unit state
    typedef enum logic {
        RUN,
        FLUSH
    } commit_state_e;

endpackage

`default_nettype wire
